//--- flist.f
mem_bus_pkg.sv
mem_map_pkg.sv
mem_arbiter.sv
sram_ctrl.sv
sram_array.sv
mem_subsys_top.sv
tb_mem_subsys_sva.sv
tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the pass line appears
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_mem_subsys \
    -f flist.f

# the simulator status alone does not decide the result
sim_out=$(./obj_dir/Vtb_mem_subsys) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- tb_mem_subsys.sv
// simulation only; reads of never-written RAM words are not modelled, so the tests write a word before reading it
module tb_mem_subsys;

    timeunit 1ns;
    timeprecision 100ps;

    import mem_bus_pkg::*;
    import mem_map_pkg::*;

    // cycles a master waits for its ack before the run is abandoned
    localparam int TIMEOUT_CYCLES = 64;
    // transfers per master in the random traffic test
    localparam int RANDOM_XFERS = 160;

    logic     clk;
    logic     reset;
    addr_t    instr_addr;
    data_t    instr_wdata;
    logic     instr_access;
    logic     instr_wr_en;
    bytesel_t instr_bytesel;
    data_t    instr_rdata;
    logic     instr_ack;
    addr_t    data_addr;
    data_t    data_wdata;
    logic     data_access;
    logic     data_wr_en;
    bytesel_t data_bytesel;
    data_t    data_rdata;
    logic     data_ack;

    // reference memory, keyed by word address
    data_t       model [addr_t];
    logic [31:0] lfsr_state;
    string       test_name;
    int          errors;
    int          checks;
    int          tests_run;
    int          reads_checked;
    int          writes_seen;
    int          test_errors_at_start;

    mem_subsys_top dut (
        .clk           (clk),
        .reset         (reset),
        .instr_addr    (instr_addr),
        .instr_wdata   (instr_wdata),
        .instr_access  (instr_access),
        .instr_wr_en   (instr_wr_en),
        .instr_bytesel (instr_bytesel),
        .instr_rdata   (instr_rdata),
        .instr_ack     (instr_ack),
        .data_addr     (data_addr),
        .data_wdata    (data_wdata),
        .data_access   (data_access),
        .data_wr_en    (data_wr_en),
        .data_bytesel  (data_bytesel),
        .data_rdata    (data_rdata),
        .data_ack      (data_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, shifted towards the msb
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // what a full-word read must return, from the memory map rules
    function automatic data_t expected_read(input addr_t a);
        if (a >= addr_t'(RAM_WORDS))
            return UNMAPPED_DATA;
        if (model.exists(a))
            return model[a];
        return '0;
    endfunction

    // byte-lane merge; writes past the end of RAM vanish
    function automatic void update_model(input addr_t a, input data_t wd, input bytesel_t bs);
        data_t word;
        if (a < addr_t'(RAM_WORDS)) begin
            word = model.exists(a) ? model[a] : '0;
            if (bs[0])
                word[7:0] = wd[7:0];
            if (bs[1])
                word[15:8] = wd[15:8];
            model[a] = word;
        end
    endfunction

    function automatic data_t word_pattern(input int m, input int i);
        return data_t'(16'hc0de + 16'h0111 * i + 16'h5000 * m);
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("test %s: %0d errors", test_name, errors - test_errors_at_start);
    endtask

    // fields go out on a rising edge and stay until the ack cycle is seen
    task automatic instr_transfer(input addr_t a, input data_t wd, input logic we,
                                  input bytesel_t bs, output int cyc, output data_t rd);
        int n;
        n = 0;
        rd = '0;
        @(posedge clk);
        instr_addr    <= a;
        instr_wdata   <= wd;
        instr_wr_en   <= we;
        instr_bytesel <= bs;
        instr_access  <= 1'b1;
        @(negedge clk);
        while (!instr_ack && n < TIMEOUT_CYCLES) begin
            n++;
            @(negedge clk);
        end
        if (!instr_ack)
            abort_run("instruction master saw no ack within the timeout");
        else
            rd = instr_rdata;
        cyc = n;
        @(posedge clk);
        instr_access <= 1'b0;
    endtask

    task automatic data_transfer(input addr_t a, input data_t wd, input logic we,
                                 input bytesel_t bs, output int cyc, output data_t rd);
        int n;
        n = 0;
        rd = '0;
        @(posedge clk);
        data_addr    <= a;
        data_wdata   <= wd;
        data_wr_en   <= we;
        data_bytesel <= bs;
        data_access  <= 1'b1;
        @(negedge clk);
        while (!data_ack && n < TIMEOUT_CYCLES) begin
            n++;
            @(negedge clk);
        end
        if (!data_ack)
            abort_run("data master saw no ack within the timeout");
        else
            rd = data_rdata;
        cyc = n;
        @(posedge clk);
        data_access <= 1'b0;
    endtask

    // single master on the bus, so latency is fixed
    task automatic lone_xfer(input bit use_data, input addr_t a, input data_t wd,
                             input logic we, input bytesel_t bs, output data_t rd);
        int cyc;
        if (use_data)
            data_transfer(a, wd, we, bs, cyc, rd);
        else
            instr_transfer(a, wd, we, bs, cyc, rd);
        check_value("ack latency", 32'(WAIT_STATES + 1), 32'(cyc));
    endtask

    task automatic score_ack(input addr_t a, input data_t wd, input logic we,
                             input bytesel_t bs, input data_t rd);
        if (we) begin
            update_model(a, wd, bs);
            writes_seen++;
        end else begin
            check_value($sformatf("read @%h", a), 32'(expected_read(a)), 32'(rd));
            reads_checked++;
        end
    endtask

    // acks are serialized by the arbiter, so ack order is memory order
    // a master that is not being acked must see zero read data
    always @(negedge clk) begin
        if (!reset) begin
            if (instr_ack)
                score_ack(instr_addr, instr_wdata, instr_wr_en, instr_bytesel, instr_rdata);
            else
                check_value("instr_rdata outside ack", 32'h0, 32'(instr_rdata));
            if (data_ack)
                score_ack(data_addr, data_wdata, data_wr_en, data_bytesel, data_rdata);
            else
                check_value("data_rdata outside ack", 32'h0, 32'(data_rdata));
        end
    end

    task automatic test_reset_idle();
        data_t rd;
        start_test("reset_idle");
        repeat (6) begin
            @(negedge clk);
            check_value("instr_ack idle", 32'h0, 32'(instr_ack));
            check_value("data_ack idle", 32'h0, 32'(data_ack));
        end
        lone_xfer(1'b0, 19'h00042, 16'h600d, 1'b1, 2'b11, rd);
        lone_xfer(1'b0, 19'h00042, 16'h0000, 1'b0, 2'b11, rd);
        check_value("first read", 32'h600d, 32'(rd));
        finish_test();
    endtask

    task automatic test_lone_word();
        data_t rd;
        start_test("lone_word");
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < 4; i++)
                lone_xfer(m == 1, addr_t'(16 + 16 * m + i), word_pattern(m, i), 1'b1, 2'b11, rd);
            for (int i = 0; i < 4; i++) begin
                lone_xfer(m == 1, addr_t'(16 + 16 * m + i), 16'h0000, 1'b0, 2'b11, rd);
                check_value("readback", 32'(word_pattern(m, i)), 32'(rd));
            end
        end
        finish_test();
    endtask

    task automatic test_byte_lanes();
        data_t rd;
        start_test("byte_lanes");
        lone_xfer(1'b1, 19'h00100, 16'h1234, 1'b1, 2'b11, rd);
        lone_xfer(1'b0, 19'h00100, 16'h55ab, 1'b1, 2'b01, rd);
        lone_xfer(1'b1, 19'h00100, 16'h0000, 1'b0, 2'b11, rd);
        check_value("low lane merge", 32'h12ab, 32'(rd));
        lone_xfer(1'b0, 19'h00100, 16'hcd77, 1'b1, 2'b10, rd);
        lone_xfer(1'b0, 19'h00100, 16'h0000, 1'b0, 2'b11, rd);
        check_value("high lane merge", 32'hcdab, 32'(rd));
        finish_test();
    endtask

    task automatic test_tie();
        int    dcyc;
        int    icyc;
        data_t drd;
        data_t ird;
        start_test("same_cycle_tie");
        lone_xfer(1'b1, 19'h00200, 16'haaaa, 1'b1, 2'b11, drd);
        lone_xfer(1'b0, 19'h00201, 16'h5555, 1'b1, 2'b11, ird);
        // both tasks raise access on the same edge
        fork
            data_transfer(19'h00200, 16'h0000, 1'b0, 2'b11, dcyc, drd);
            instr_transfer(19'h00201, 16'h0000, 1'b0, 2'b11, icyc, ird);
        join
        check_value("data acked first on read", 32'h1, 32'(dcyc < icyc));
        check_value("data read", 32'haaaa, 32'(drd));
        check_value("instr read", 32'h5555, 32'(ird));
        fork
            data_transfer(19'h00200, 16'h1357, 1'b1, 2'b11, dcyc, drd);
            instr_transfer(19'h00201, 16'h2468, 1'b1, 2'b11, icyc, ird);
        join
        check_value("data acked first on write", 32'h1, 32'(dcyc < icyc));
        lone_xfer(1'b0, 19'h00200, 16'h0000, 1'b0, 2'b11, drd);
        check_value("data write landed", 32'h1357, 32'(drd));
        lone_xfer(1'b1, 19'h00201, 16'h0000, 1'b0, 2'b11, ird);
        check_value("instr write landed", 32'h2468, 32'(ird));
        finish_test();
    endtask

    task automatic test_unmapped();
        data_t rd;
        start_test("unmapped");
        lone_xfer(1'b1, 19'h00000, 16'h0a0a, 1'b1, 2'b11, rd);
        lone_xfer(1'b1, addr_t'(RAM_WORDS - 1), 16'hbeef, 1'b1, 2'b11, rd);
        // these alias words 0 and RAM_WORDS-1 in the low index bits
        lone_xfer(1'b0, addr_t'(RAM_WORDS), 16'h5555, 1'b1, 2'b11, rd);
        lone_xfer(1'b1, 19'h7ffff, 16'h1111, 1'b1, 2'b11, rd);
        lone_xfer(1'b0, addr_t'(RAM_WORDS), 16'h0000, 1'b0, 2'b11, rd);
        check_value("read at RAM end", 32'hffff, 32'(rd));
        lone_xfer(1'b1, 19'h7ffff, 16'h0000, 1'b0, 2'b11, rd);
        check_value("read at top", 32'hffff, 32'(rd));
        lone_xfer(1'b0, 19'h00000, 16'h0000, 1'b0, 2'b11, rd);
        check_value("word 0 kept", 32'h0a0a, 32'(rd));
        lone_xfer(1'b1, addr_t'(RAM_WORDS - 1), 16'h0000, 1'b0, 2'b11, rd);
        check_value("last word kept", 32'hbeef, 32'(rd));
        finish_test();
    endtask

    // 16-word window, half mapped and half past the end of RAM
    task automatic random_traffic(input bit use_data);
        addr_t    a;
        data_t    wd;
        logic     we;
        bytesel_t bs;
        data_t    rd;
        int       cyc;
        for (int k = 0; k < RANDOM_XFERS; k++) begin
            a  = addr_t'(RAM_WORDS - 8) + addr_t'(rand_bits(4));
            we = rand_bits(1) != 0;
            bs = bytesel_t'(rand_bits(2));
            wd = data_t'(rand_bits(16));
            if (use_data)
                data_transfer(a, wd, we, bs, cyc, rd);
            else
                instr_transfer(a, wd, we, bs, cyc, rd);
        end
    endtask

    task automatic test_random();
        data_t rd;
        start_test("random_mixed");
        // every window word gets a known value first
        for (int i = 0; i < 16; i++)
            lone_xfer(1'b1, addr_t'(RAM_WORDS - 8 + i), data_t'(rand_bits(16)), 1'b1, 2'b11, rd);
        fork
            random_traffic(1'b0);
            random_traffic(1'b1);
        join
        finish_test();
    endtask

    initial begin
        lfsr_state    = 32'h4d0c_829d;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        reads_checked = 0;
        writes_seen   = 0;
        test_name     = "reset";
        reset         = 1'b1;
        instr_addr    = '0;
        instr_wdata   = '0;
        instr_access  = 1'b0;
        instr_wr_en   = 1'b0;
        instr_bytesel = '0;
        data_addr     = '0;
        data_wdata    = '0;
        data_access   = 1'b0;
        data_wr_en    = 1'b0;
        data_bytesel  = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_reset_idle();
        test_lone_word();
        test_byte_lanes();
        test_tie();
        test_unmapped();
        test_random();
        $display("counts: %0d tests, %0d checks, %0d reads, %0d writes, %0d errors",
                 tests_run, checks, reads_checked, writes_seen, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb_mem_subsys_sva.sv
// handshake properties only, sampled on the rising clock and ignored while reset is high
module tb_mem_subsys_sva (
    input logic clk,
    input logic reset,
    input logic instr_access,
    input logic instr_ack,
    input logic data_access,
    input logic data_ack,
    input logic mem_access,
    input logic mem_ack
);

    timeunit 1ns;
    timeprecision 100ps;

    import mem_map_pkg::*;

    // one memory port, so one ack at a time
    a_single_ack: assert property (@(posedge clk) disable iff (reset)
        !(instr_ack && data_ack))
        else $error("instr_ack and data_ack are high in the same cycle");

    // controller must not see a new request during its own ack
    // and each ack answers the access it took WAIT_STATES plus 1 cycles before
    a_no_access_in_ack: assert property (@(posedge clk) disable iff (reset)
        mem_ack |-> !mem_access && $past(mem_access, WAIT_STATES + 1))
        else $error("mem_access high in a mem_ack cycle or ack without its request");

    // an ack always answers a held request
    a_instr_ack_held: assert property (@(posedge clk) disable iff (reset)
        instr_ack |-> instr_access)
        else $error("instr_ack without instr_access");

    a_data_ack_held: assert property (@(posedge clk) disable iff (reset)
        data_ack |-> data_access)
        else $error("data_ack without data_access");

endmodule

// reaches the arbiter to controller port inside the top level
bind mem_subsys_top tb_mem_subsys_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .instr_access (instr_access),
    .instr_ack    (instr_ack),
    .data_access  (data_access),
    .data_ack     (data_ack),
    .mem_access   (mem_access),
    .mem_ack      (mem_ack)
);

//--- mem_subsys_top.sv
// two masters share one SRAM port; a lone request is acked WAIT_STATES plus 1 cycles after access
module mem_subsys_top (
    input  logic                 clk,
    input  logic                 reset,

    // instruction fetch master
    input  mem_bus_pkg::addr_t    instr_addr,
    input  mem_bus_pkg::data_t    instr_wdata,
    input  logic                 instr_access,
    input  logic                 instr_wr_en,
    input  mem_bus_pkg::bytesel_t instr_bytesel,
    output mem_bus_pkg::data_t    instr_rdata,
    output logic                 instr_ack,

    // data master
    input  mem_bus_pkg::addr_t    data_addr,
    input  mem_bus_pkg::data_t    data_wdata,
    input  logic                 data_access,
    input  logic                 data_wr_en,
    input  mem_bus_pkg::bytesel_t data_bytesel,
    output mem_bus_pkg::data_t    data_rdata,
    output logic                 data_ack
);

    import mem_bus_pkg::*;
    import mem_map_pkg::*;

    // arbiter to controller
    addr_t    mem_addr;
    data_t    mem_wdata;
    logic     mem_access;
    logic     mem_wr_en;
    bytesel_t mem_bytesel;
    data_t    mem_rdata;
    logic     mem_ack;

    // controller to array
    word_index_t ram_index;
    data_t       ram_wdata;
    bytesel_t    ram_byte_we;
    logic        ram_rd_en;
    data_t       ram_rdata;

    mem_arbiter u_arbiter (
        .clk           (clk),
        .reset         (reset),
        .instr_addr    (instr_addr),
        .instr_wdata   (instr_wdata),
        .instr_access  (instr_access),
        .instr_wr_en   (instr_wr_en),
        .instr_bytesel (instr_bytesel),
        .instr_rdata   (instr_rdata),
        .instr_ack     (instr_ack),
        .data_addr     (data_addr),
        .data_wdata    (data_wdata),
        .data_access   (data_access),
        .data_wr_en    (data_wr_en),
        .data_bytesel  (data_bytesel),
        .data_rdata    (data_rdata),
        .data_ack      (data_ack),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_access    (mem_access),
        .mem_wr_en     (mem_wr_en),
        .mem_bytesel   (mem_bytesel),
        .mem_rdata     (mem_rdata),
        .mem_ack       (mem_ack)
    );

    sram_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_access  (mem_access),
        .mem_wr_en   (mem_wr_en),
        .mem_bytesel (mem_bytesel),
        .mem_rdata   (mem_rdata),
        .mem_ack     (mem_ack),
        .ram_index   (ram_index),
        .ram_wdata   (ram_wdata),
        .ram_byte_we (ram_byte_we),
        .ram_rd_en   (ram_rd_en),
        .ram_rdata   (ram_rdata)
    );

    sram_array u_array (
        .clk         (clk),
        .ram_index   (ram_index),
        .ram_wdata   (ram_wdata),
        .ram_byte_we (ram_byte_we),
        .ram_rd_en   (ram_rd_en),
        .ram_rdata   (ram_rdata)
    );

endmodule

//--- sram_array.sv
// contents are undefined until written; one access per cycle, read data appears after the next edge
module sram_array (
    input  logic                     clk,
    input  mem_map_pkg::word_index_t  ram_index,
    input  mem_bus_pkg::data_t        ram_wdata,
    input  mem_bus_pkg::bytesel_t     ram_byte_we,
    input  logic                     ram_rd_en,
    output mem_bus_pkg::data_t        ram_rdata
);

    import mem_bus_pkg::*;
    import mem_map_pkg::*;

    // word storage
    data_t mem_words [RAM_WORDS];

    // per-lane writes
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < BYTESEL_W; lane++) begin
            if (ram_byte_we[lane])
                mem_words[ram_index][lane*BYTE_W +: BYTE_W] <=
                    ram_wdata[lane*BYTE_W +: BYTE_W];
        end
    end

    // registered read port, holds its value between reads
    always_ff @(posedge clk) begin
        if (ram_rd_en)
            ram_rdata <= mem_words[ram_index];
    end

endmodule

//--- sram_ctrl.sv
// fixed WAIT_STATES latency per request, no pipelining; write acks return zero data, unmapped acks all ones
module sram_ctrl (
    input  logic                     clk,
    input  logic                     reset,

    // request from the arbiter
    input  mem_bus_pkg::addr_t        mem_addr,
    input  mem_bus_pkg::data_t        mem_wdata,
    input  logic                     mem_access,
    input  logic                     mem_wr_en,
    input  mem_bus_pkg::bytesel_t     mem_bytesel,

    // response to the arbiter
    output mem_bus_pkg::data_t        mem_rdata,
    output logic                     mem_ack,

    // array port
    output mem_map_pkg::word_index_t  ram_index,
    output mem_bus_pkg::data_t        ram_wdata,
    output mem_bus_pkg::bytesel_t     ram_byte_we,
    output logic                     ram_rd_en,
    input  mem_bus_pkg::data_t        ram_rdata
);

    import mem_bus_pkg::*;
    import mem_map_pkg::*;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_WAIT,
        CTRL_ACK
    } ctrl_state_t;

    ctrl_state_t state;
    wait_cnt_t   wait_cnt;

    logic  accept;
    logic  addr_mapped;
    logic  req_mapped;
    logic  req_is_read;
    logic  rd_pending;
    data_t rdata_q;

    // a request is taken only from idle
    assign accept = (state == CTRL_IDLE) && mem_access;

    // address decode against the populated RAM
    assign addr_mapped = mem_addr < addr_t'(RAM_WORDS);

    // array access goes out in the accept cycle, while the master still holds the fields
    assign ram_index   = mem_addr[RAM_INDEX_W-1:0];
    assign ram_wdata   = mem_wdata;
    assign ram_byte_we = (accept && addr_mapped && mem_wr_en) ? mem_bytesel : '0;
    assign ram_rd_en   = accept && addr_mapped && !mem_wr_en;

    assign mem_ack = (state == CTRL_ACK);

    always_comb begin
        mem_rdata = '0;
        if (mem_ack) begin
            if (!req_mapped)
                mem_rdata = UNMAPPED_DATA;
            else if (req_is_read)
                mem_rdata = rdata_q;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= CTRL_IDLE;
            wait_cnt    <= '0;
            req_mapped  <= 1'b0;
            req_is_read <= 1'b0;
            rd_pending  <= 1'b0;
        end else begin
            // capture strobe lasts one cycle
            rd_pending <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    if (mem_access) begin
                        state       <= CTRL_WAIT;
                        wait_cnt    <= wait_cnt_t'(WAIT_STATES - 1);
                        req_mapped  <= addr_mapped;
                        req_is_read <= !mem_wr_en;
                        rd_pending  <= ram_rd_en;
                    end
                end
                CTRL_WAIT: begin
                    // last wait cycle when the counter has run down
                    if (wait_cnt == '0)
                        state <= CTRL_ACK;
                    else
                        wait_cnt <= wait_cnt - wait_cnt_t'(1);
                end
                CTRL_ACK: begin
                    state <= CTRL_IDLE;
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // array output is valid the cycle after the read strobe, hold it for the ack
    always_ff @(posedge clk) begin
        if (rd_pending)
            rdata_q <= ram_rdata;
    end

endmodule

//--- mem_arbiter.sv
// masters must hold access and all request fields until ack; data wins ties and can starve fetches
module mem_arbiter (
    input  logic                 clk,
    input  logic                 reset,

    // instruction fetch master
    input  mem_bus_pkg::addr_t    instr_addr,
    input  mem_bus_pkg::data_t    instr_wdata,
    input  logic                 instr_access,
    input  logic                 instr_wr_en,
    input  mem_bus_pkg::bytesel_t instr_bytesel,
    output mem_bus_pkg::data_t    instr_rdata,
    output logic                 instr_ack,

    // data master
    input  mem_bus_pkg::addr_t    data_addr,
    input  mem_bus_pkg::data_t    data_wdata,
    input  logic                 data_access,
    input  logic                 data_wr_en,
    input  mem_bus_pkg::bytesel_t data_bytesel,
    output mem_bus_pkg::data_t    data_rdata,
    output logic                 data_ack,

    // shared memory port
    output mem_bus_pkg::addr_t    mem_addr,
    output mem_bus_pkg::data_t    mem_wdata,
    output logic                 mem_access,
    output logic                 mem_wr_en,
    output mem_bus_pkg::bytesel_t mem_bytesel,
    input  mem_bus_pkg::data_t    mem_rdata,
    input  logic                 mem_ack
);

    logic grant_active;
    logic grant_to_data;
    logic sel_data;
    logic sel_access;

    // with no grant held, a data request takes the port straight away
    assign sel_data = grant_active ? grant_to_data : data_access;

    // request steering
    assign mem_addr    = sel_data ? data_addr : instr_addr;
    assign mem_wdata   = sel_data ? data_wdata : instr_wdata;
    assign mem_wr_en   = sel_data ? data_wr_en : instr_wr_en;
    assign mem_bytesel = sel_data ? data_bytesel : instr_bytesel;
    assign sel_access  = sel_data ? data_access : instr_access;

    // the controller must not see a new request while it is acking the old one
    assign mem_access = sel_access & ~mem_ack;

    // responses only to the owner of the grant
    assign instr_ack = grant_active & ~grant_to_data & mem_ack;
    assign data_ack  = grant_active & grant_to_data & mem_ack;

    // read data is zero outside the owner's ack cycle
    assign instr_rdata = instr_ack ? mem_rdata : '0;
    assign data_rdata  = data_ack ? mem_rdata : '0;

    // grant is taken on the same edge the controller accepts the request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_active  <= 1'b0;
            grant_to_data <= 1'b0;
        end else if (mem_ack) begin
            // re-arbitrate after every transfer
            grant_active <= 1'b0;
        end else if (!grant_active && (instr_access || data_access)) begin
            grant_active  <= 1'b1;
            grant_to_data <= data_access;
        end
    end

endmodule

//--- mem_map_pkg.sv
// RAM occupies the bottom of the word space only; everything above it reads as all ones and drops writes
package mem_map_pkg;

    // populated RAM size in words, word addresses below this hit the array
    localparam int RAM_WORDS = 32768;
    localparam int RAM_INDEX_W = $clog2(RAM_WORDS);

    // index into the populated RAM
    typedef logic [RAM_INDEX_W-1:0] word_index_t;

    // read value for addresses past the end of RAM
    localparam mem_bus_pkg::data_t UNMAPPED_DATA = 16'hffff;

    // idle cycles between accepting a request and acking it, must be 1 or more
    localparam int WAIT_STATES = 2;

    // wait-state down counter
    localparam int WAIT_CNT_W = $clog2(WAIT_STATES + 1);
    typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;

endpackage

//--- mem_bus_pkg.sv
// word-addressed bus fields shared by both masters, the arbiter and the controller; no byte address bit 0
package mem_bus_pkg;

    // word address width, covers byte address bits 19 down to 1
    localparam int ADDR_W = 19;

    // one bus word is two bytes
    localparam int DATA_W = 16;
    localparam int BYTE_W = 8;

    // one select bit per byte lane
    localparam int BYTESEL_W = DATA_W / BYTE_W;

    // word address as seen by a master
    typedef logic [ADDR_W-1:0] addr_t;

    // read or write data word
    typedef logic [DATA_W-1:0] data_t;

    // bit 0 is the low byte, bit 1 the high byte
    // only writes look at it, reads always return the whole word
    typedef logic [BYTESEL_W-1:0] bytesel_t;

endpackage
